/* project.f */
rtl/memshare_pkg.sv
rtl/type0_reg_array.sv
rtl/slice_delay_line.sv
rtl/l1pa_delta_regfile.sv
testbench/tb_clock_gen.sv
testbench/tb_l1pa_checker.sv
testbench/tb_l1pa_delta_regfile.sv

/* testbench/tb_l1pa_delta_regfile.sv */
/*
 * testbench top with clock, DUT, checker, phased stimulus and timeout
 */
`timescale 1ns/10ps

module tb_l1pa_delta_regfile
    import memshare_pkg::*;
();

    localparam int RD_CYCLE       = 2;
    localparam int RANDOM_CYCLES  = 400;
    // roughly 530 cycles of phases plus margin
    localparam int TIMEOUT_CYCLES = 1000;

    logic   sys_clk;
    logic   rstn;
    logic   delta_clear_n;
    logic   regtype0_we;
    addr_t  regtype0_waddr;
    page_t  regtype0_wdata;
    addr_t  regtype0_raddr;
    shift_t l1pa_shift;
    delta_t shift_delta;
    logic   is_gtr;

    int check_count;
    int shift_err;
    int delta_err;
    int gtr_err;
    int cycle_count;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .sys_clk_o (sys_clk),
        .rstn_o    (rstn)
    );

    l1pa_delta_regfile #(
        .RD_CYCLE (RD_CYCLE)
    ) dut (
        .sys_clk          (sys_clk),
        .rstn             (rstn),
        .delta_clear_n_i  (delta_clear_n),
        .regtype0_we_i    (regtype0_we),
        .regtype0_waddr_i (regtype0_waddr),
        .regtype0_wdata_i (regtype0_wdata),
        .regtype0_raddr_i (regtype0_raddr),
        .l1pa_shift_o     (l1pa_shift),
        .shift_delta_o    (shift_delta),
        .is_gtr_o         (is_gtr)
    );

    tb_l1pa_checker #(
        .RD_CYCLE (RD_CYCLE)
    ) u_checker (
        .sys_clk          (sys_clk),
        .rstn             (rstn),
        .delta_clear_n_i  (delta_clear_n),
        .regtype0_we_i    (regtype0_we),
        .regtype0_waddr_i (regtype0_waddr),
        .regtype0_wdata_i (regtype0_wdata),
        .regtype0_raddr_i (regtype0_raddr),
        .l1pa_shift_i     (l1pa_shift),
        .shift_delta_i    (shift_delta),
        .is_gtr_i         (is_gtr),
        .check_count_o    (check_count),
        .shift_err_o      (shift_err),
        .delta_err_o      (delta_err),
        .gtr_err_o        (gtr_err)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    // one access per cycle applied on the falling edge
    task automatic drive_cycle(input logic we, input addr_t waddr, input page_t wdata,
                               input addr_t raddr, input logic clear_n);
        @(negedge sys_clk);
        regtype0_we    = we;
        regtype0_waddr = waddr;
        regtype0_wdata = wdata;
        regtype0_raddr = raddr;
        delta_clear_n  = clear_n;
    endtask

    // odd multiplier keeps the 32 fill values distinct
    function automatic page_t fill_value(input addr_t a);
        return page_t'(a * 37 + 5);
    endfunction

    task automatic print_summary();
        $display("checks=%0d errors: shift=%0d delta=%0d gtr=%0d",
                 check_count, shift_err, delta_err, gtr_err);
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin : stimulus
        logic        rnd_we;
        logic        rnd_clear_n;
        addr_t       rnd_waddr;
        addr_t       rnd_raddr;
        page_t       rnd_wdata;
        regtype0_we    = 1'b0;
        regtype0_waddr = '0;
        regtype0_wdata = '0;
        regtype0_raddr = '0;
        // held low in reset so the delta line starts at zero too
        delta_clear_n  = 1'b0;
        void'($urandom(32'hcb0c));

        wait (rstn === 1'b1);
        delta_clear_n = 1'b1;

        // outputs still carry the zeroed reset items
        repeat (RD_CYCLE) drive_cycle(1'b0, '0, '0, '0, 1'b1);

        // fill every page
        for (int i = 0; i < 32; i++) begin
            drive_cycle(1'b1, addr_t'(i), fill_value(addr_t'(i)), '0, 1'b1);
        end

        // back to back reads in ascending then stride order
        for (int i = 0; i < 32; i++) begin
            drive_cycle(1'b0, '0, '0, addr_t'(i), 1'b1);
        end
        for (int i = 31; i >= 0; i--) begin
            drive_cycle(1'b0, '0, '0, addr_t'((i * 7) % 32), 1'b1);
        end

        // write priority with the read address ignored during the write
        drive_cycle(1'b1, 5'd5, 7'h2a, 5'd20, 1'b1);
        drive_cycle(1'b0, '0, '0, 5'd5, 1'b1);
        drive_cycle(1'b1, 5'd9, 7'h55, 5'd9, 1'b1);
        drive_cycle(1'b0, '0, '0, 5'd9, 1'b1);

        // delta clear on the middle two of four pages with nonzero delta
        drive_cycle(1'b0, '0, '0, 5'd11, 1'b1);
        drive_cycle(1'b0, '0, '0, 5'd13, 1'b0);
        drive_cycle(1'b0, '0, '0, 5'd14, 1'b0);
        drive_cycle(1'b0, '0, '0, 5'd16, 1'b1);

        // random mix of writes, reads and clear pulses
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd_we      = ($urandom % 4) == 0;
            rnd_waddr   = addr_t'($urandom);
            rnd_wdata   = page_t'($urandom);
            rnd_raddr   = addr_t'($urandom);
            rnd_clear_n = ($urandom % 8) != 0;
            drive_cycle(rnd_we, rnd_waddr, rnd_wdata, rnd_raddr, rnd_clear_n);
        end

        // let the last items reach the outputs
        repeat (RD_CYCLE + 2) drive_cycle(1'b0, '0, '0, '0, 1'b1);
        @(posedge sys_clk);

        if (check_count == 0) begin
            $display("error: the checker compared no outputs");
        end
        print_summary();
        if (check_count > 0 && shift_err + delta_err + gtr_err == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // ------------------------------
    // timeout
    // ------------------------------

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        print_summary();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* testbench/tb_l1pa_checker.sv */
/*
 * reference model of the page array, expected-value function
 * and the output comparison with per-field error counts
 */
`timescale 1ns/10ps

module tb_l1pa_checker
    import memshare_pkg::*;
#(
    parameter int RD_CYCLE = 2
) (
    input  logic   sys_clk,
    input  logic   rstn,
    input  logic   delta_clear_n_i,
    input  logic   regtype0_we_i,
    input  addr_t  regtype0_waddr_i,
    input  page_t  regtype0_wdata_i,
    input  addr_t  regtype0_raddr_i,
    input  shift_t l1pa_shift_i,
    input  delta_t shift_delta_i,
    input  logic   is_gtr_i,
    output int     check_count_o,
    output int     shift_err_o,
    output int     delta_err_o,
    output int     gtr_err_o
);

    // one expectation per sampled cycle
    // chk bits say whether the field is known well enough to compare
    typedef struct packed {
        logic [2:0] shift;
        logic [2:0] delta;
        logic       gtr;
        logic       shift_chk;
        logic       delta_chk;
    } expect_t;

    // model pages and which of them have been written
    page_t   model_page  [32];
    logic    model_known [32];
    expect_t pending_q   [$];

    initial begin
        check_count_o = 0;
        shift_err_o   = 0;
        delta_err_o   = 0;
        gtr_err_o     = 0;
        for (int i = 0; i < 32; i++) begin
            model_known[i] = 1'b0;
            model_page[i]  = '0;
        end
    end

    // ------------------------------
    // reference function
    // ------------------------------

    // shift is bits 6..4, delta bits 3..1, flag bit 0
    function automatic expect_t predict_fields(input page_t page, input logic known,
                                               input logic rst_n, input logic clr_n);
        expect_t e;
        e.shift     = page[6:4];
        e.delta     = page[3:1];
        e.gtr       = page[0];
        e.shift_chk = known;
        e.delta_chk = known;
        // reset zeroes shift and flag of the item sampled with it
        if (!rst_n) begin
            e.shift     = 3'd0;
            e.gtr       = 1'b0;
            e.shift_chk = 1'b1;
        end
        // delta clear only touches the delta
        if (!clr_n) begin
            e.delta     = 3'd0;
            e.delta_chk = 1'b1;
        end
        return e;
    endfunction

    // ------------------------------
    // sample side
    // ------------------------------

    // inputs are stable at the rising edge
    always @(posedge sys_clk) begin : sample_side
        addr_t acc;
        // write address wins the single port
        acc = regtype0_we_i ? regtype0_waddr_i : regtype0_raddr_i;
        pending_q.push_back(predict_fields(model_page[acc], model_known[acc],
                                           rstn, delta_clear_n_i));
        // model update after the prediction, so a write shows old data
        if (regtype0_we_i) begin
            model_page[regtype0_waddr_i]  = regtype0_wdata_i;
            model_known[regtype0_waddr_i] = 1'b1;
        end
    end

    // ------------------------------
    // compare side
    // ------------------------------

    // outputs settle after the rising edge, read them mid-cycle
    always @(negedge sys_clk) begin : compare_side
        expect_t e;
        if (pending_q.size() >= RD_CYCLE) begin
            e = pending_q.pop_front();
            if (e.shift_chk) begin
                check_count_o++;
                if (l1pa_shift_i !== e.shift) begin
                    shift_err_o++;
                    $display("MISMATCH time=%0t signal=l1pa_shift_o expected=%0h actual=%0h",
                             $time, e.shift, l1pa_shift_i);
                end
                if (is_gtr_i !== e.gtr) begin
                    gtr_err_o++;
                    $display("MISMATCH time=%0t signal=is_gtr_o expected=%0h actual=%0h",
                             $time, e.gtr, is_gtr_i);
                end
            end
            if (e.delta_chk) begin
                check_count_o++;
                if (shift_delta_i !== e.delta) begin
                    delta_err_o++;
                    $display("MISMATCH time=%0t signal=shift_delta_o expected=%0h actual=%0h",
                             $time, e.delta, shift_delta_i);
                end
            end
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * testbench clock and reset generator
 */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic sys_clk_o,
    output logic rstn_o
);

    // free running clock, first rising edge half a period in
    initial begin
        sys_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk_o = ~sys_clk_o;
    end

    // reset low for RESET_CYCLES rising edges, released on a falling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk_o);
        @(negedge sys_clk_o);
        rstn_o = 1'b1;
    end

endmodule

/* rtl/l1pa_delta_regfile.sv */
/*
 * L1PA delta register file top level
 * page array, field split, shift/flag and delta slice lines
 */
`timescale 1ns/10ps

module l1pa_delta_regfile
    import memshare_pkg::*;
#(
    // read latency in cycles, 1 to 4
    parameter int RD_CYCLE = 2
) (
    input  logic   sys_clk,
    input  logic   rstn,

    // active low, clears the delta of the read sampled with it
    input  logic   delta_clear_n_i,

    // write port
    input  logic   regtype0_we_i,
    input  addr_t  regtype0_waddr_i,
    input  page_t  regtype0_wdata_i,

    // read port
    input  addr_t  regtype0_raddr_i,

    // fields of the page, RD_CYCLE cycles after the address
    output shift_t l1pa_shift_o,
    output delta_t shift_delta_o,
    output logic   is_gtr_o
);

    // ------------------------------
    // register array
    // ------------------------------

    // page at the access address, combinational
    page_t read_page;

    type0_reg_array #(
        .PAGE_NUM (PAGE_NUM)
    ) u_type0_reg_array (
        .sys_clk          (sys_clk),
        .regtype0_we_i    (regtype0_we_i),
        .regtype0_waddr_i (regtype0_waddr_i),
        .regtype0_wdata_i (regtype0_wdata_i),
        .regtype0_raddr_i (regtype0_raddr_i),
        .read_page_o      (read_page)
    );

    // ------------------------------
    // field split
    // ------------------------------

    // shift and flag share one line
    shift_gtr_t shift_gtr_in;
    shift_gtr_t shift_gtr_out;

    // delta has its own line because of its own clear
    delta_t delta_in;
    delta_t delta_out;

    assign shift_gtr_in.shift = read_page[SHIFT_LSB +: SHIFT_W];
    assign shift_gtr_in.gtr   = read_page[GTR_BIT];
    assign delta_in           = read_page[DELTA_LSB +: DELTA_W];

    // ------------------------------
    // slice stages
    // ------------------------------

    // shift and flag, cleared by the system reset
    slice_delay_line #(
        .payload_t (shift_gtr_t),
        .DEPTH     (RD_CYCLE)
    ) u_shift_gtr_line (
        .sys_clk   (sys_clk),
        .clear_n_i (rstn),
        .data_i    (shift_gtr_in),
        .data_o    (shift_gtr_out)
    );

    // delta, cleared per item by the delta clear
    slice_delay_line #(
        .payload_t (delta_t),
        .DEPTH     (RD_CYCLE)
    ) u_delta_line (
        .sys_clk   (sys_clk),
        .clear_n_i (delta_clear_n_i),
        .data_i    (delta_in),
        .data_o    (delta_out)
    );

    // ------------------------------
    // outputs
    // ------------------------------

    // unpack the shift/flag line
    assign l1pa_shift_o  = shift_gtr_out.shift;
    assign is_gtr_o      = shift_gtr_out.gtr;
    assign shift_delta_o = delta_out;

endmodule

/* rtl/slice_delay_line.sv */
/*
 * slice register chain of DEPTH stages for any packed payload
 * with a clear bit that rides along with each item
 */
`timescale 1ns/10ps

module slice_delay_line
    import memshare_pkg::*;
#(
    // payload carried through the stages
    parameter type payload_t = page_t,
    // number of slice stages, at least one
    parameter int  DEPTH     = 2
) (
    input  logic     sys_clk,

    // active low, zeroes the item sampled with it
    input  logic     clear_n_i,

    input  payload_t data_i,
    output payload_t data_o
);

    // ------------------------------
    // payload chain
    // ------------------------------

    // one item in flight per stage
    payload_t data_q [DEPTH];

    // first stage samples the input and its clear together
    always_ff @(posedge sys_clk) begin
        if (!clear_n_i) begin
            data_q[0] <= '0;
        end else begin
            data_q[0] <= data_i;
        end
    end

    // ------------------------------
    // later stages
    // ------------------------------

    // only present when more than one stage is asked for
    if (DEPTH > 1) begin : g_tail

        // clear bit that entered with the item now in stage k
        // one shorter than the payload chain
        logic clear_q [DEPTH-1];

        always_ff @(posedge sys_clk) begin
            clear_q[0] <= clear_n_i;
        end

        // clear bits shift along in step with the payload
        for (genvar k = 1; k < DEPTH - 1; k++) begin : g_clear
            always_ff @(posedge sys_clk) begin
                clear_q[k] <= clear_q[k-1];
            end
        end

        // each stage clears on the bit that belongs to its own item
        // so a clear never reaches back to older items
        for (genvar k = 1; k < DEPTH; k++) begin : g_stage
            always_ff @(posedge sys_clk) begin
                if (!clear_q[k-1]) begin
                    data_q[k] <= '0;
                end else begin
                    data_q[k] <= data_q[k-1];
                end
            end
        end

    end

    // last stage drives the output
    assign data_o = data_q[DEPTH-1];

endmodule

/* rtl/type0_reg_array.sv */
/*
 * type-0 register array, single access port
 * write-priority address select, sync write, async read
 */
`timescale 1ns/10ps

module type0_reg_array
    import memshare_pkg::*;
#(
    // number of pages held
    parameter int PAGE_NUM = memshare_pkg::PAGE_NUM
) (
    input  logic  sys_clk,

    // write strobe, takes the port for this cycle
    input  logic  regtype0_we_i,
    input  addr_t regtype0_waddr_i,
    input  page_t regtype0_wdata_i,

    // read address, only used while no write is pending
    input  addr_t regtype0_raddr_i,

    // page at the access address, old contents during a write
    output page_t read_page_o
);

    // ------------------------------
    // access address
    // ------------------------------

    // one port only, so the write address wins
    addr_t access_addr;

    always_comb begin
        if (regtype0_we_i) begin
            access_addr = regtype0_waddr_i;
        end else begin
            access_addr = regtype0_raddr_i;
        end
    end

    // ------------------------------
    // page storage
    // ------------------------------

    // maps onto distributed ram, contents undefined after power-up
    page_t mem_q [PAGE_NUM];

    // write lands on the rising edge
    always_ff @(posedge sys_clk) begin
        if (regtype0_we_i) begin
            mem_q[access_addr] <= regtype0_wdata_i;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------

    // asynchronous read, zero cycles of latency
    // during a write this shows the page before the update
    assign read_page_o = mem_q[access_addr];

endmodule

/* rtl/memshare_pkg.sv */
/*
 * widths, field positions and payload types shared by the
 * L1PA delta register file and its slice delay lines
 */
package memshare_pkg;

    // ------------------------------
    // register file geometry
    // ------------------------------

    // l1pa shift field
    localparam int SHIFT_W = 3;
    // shift delta field
    localparam int DELTA_W = 3;
    // one type-0 page holds shift, delta and the flag
    localparam int PAGE_W = 7;
    // page address
    localparam int ADDR_W = 5;
    // 32 pages, one per address
    localparam int PAGE_NUM = 32;

    // ------------------------------
    // field positions in a page
    // ------------------------------

    // is-greater flag sits at the bottom
    localparam int GTR_BIT = 0;
    // delta occupies bits 3..1
    localparam int DELTA_LSB = 1;
    // shift occupies bits 6..4
    localparam int SHIFT_LSB = 4;

    // ------------------------------
    // payload types
    // ------------------------------

    // raw page as stored in the array
    typedef logic [PAGE_W-1:0] page_t;

    // page address
    typedef logic [ADDR_W-1:0] addr_t;

    // l1pa shift value
    typedef logic [SHIFT_W-1:0] shift_t;

    // shift delta value
    typedef logic [DELTA_W-1:0] delta_t;

    // shift and flag travel together through one slice line
    // same bit order as in the page, shift above the flag
    typedef struct packed {
        shift_t shift;
        logic   gtr;
    } shift_gtr_t;

endpackage
